/* filelist.f */
+incdir+hdl
hdl/datapath_pkg.sv
hdl/fetch_stage.sv
hdl/scoreboard.sv
hdl/execute.sv
hdl/writeback.sv
hdl/sc_datapath.sv
test/tb_memory.sv
test/tb_sc_datapath.sv

/* test/tb_sc_datapath.sv */
// Runs the fixed program on the scalar pipeline and checks its memory ports and halt
`timescale 1ns/100ps
`default_nettype none

module tb_sc_datapath;
    import datapath_pkg::*;

    localparam int    halt_timeout   = 500;
    localparam int    halt_watch     = 16;
    localparam word_t reset_addr     = 32'h0000_0000;
    localparam word_t poison_addr    = 32'h0000_01F0;
    localparam word_t load_copy_addr = 32'h0000_0118;

    // one expected data write
    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic      CLK;
    logic      nrst;
    imem_req_t imem_req;
    imem_rsp_t imem_rsp;
    dmem_req_t dmem_req;
    dmem_rsp_t dmem_rsp;
    logic      halt;

    store_t    exp_q [$];
    int        n_expected;
    int        n_stores;
    int        errors;
    int        timeouts;
    int        wait_cycles;
    int        cycles_after_reset;
    logic      halt_risen;
    logic      prev_wait;
    dmem_req_t prev_req;
    logic      load_seen;
    word_t     load_addr;

    tb_memory i_mem (
        .CLK      (CLK),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp)
    );

    sc_datapath i_dut (
        .CLK      (CLK),
        .nrst     (nrst),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp),
        .halt     (halt)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        store_t s;
        s.addr = addr;
        s.data = data;
        exp_q.push_back(s);
    endtask

    task automatic check_idle_levels();
        assert (!dmem_req.ren && !dmem_req.wen)
            else report_mismatch("data request active around reset");
        assert (!imem_req.ren)
            else report_mismatch("instruction request active around reset");
        assert (imem_req.addr == reset_addr)
            else report_mismatch($sformatf("fetch address %h around reset", imem_req.addr));
        assert (!halt)
            else report_mismatch("halt high around reset");
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        store_t want;
        assert (addr != poison_addr)
            else report_mismatch($sformatf("store to skipped address %h", addr));
        assert (!halt_risen && !halt)
            else report_problem("a store completed after halt");
        if (exp_q.size() == 0) begin
            report_problem($sformatf("unexpected extra store to %h", addr));
        end
        else begin
            want = exp_q.pop_front();
            assert (addr == want.addr && data == want.data)
                else report_mismatch($sformatf("store %0d wrote %h to %h, expected %h to %h",
                                               n_stores, data, addr, want.data, want.addr));
        end
        // copy of the loaded word must match the model
        if (addr == load_copy_addr) begin
            assert (load_seen && data == i_mem.ram[load_addr[8:2]])
                else report_mismatch($sformatf("loaded word stored as %h", data));
        end
        n_stores++;
    endtask

    // sampled on the rising edge before any register updates
    always @(posedge CLK) begin
        if (!nrst) begin
            check_idle_levels();
            cycles_after_reset = 0;
            prev_wait          = 1'b0;
        end
        else begin
            if (cycles_after_reset == 0)
                check_idle_levels();
            cycles_after_reset++;
            assert (!(dmem_req.ren && dmem_req.wen))
                else report_mismatch("ren and wen high together");
            if (prev_wait) begin
                assert (dmem_req == prev_req)
                    else report_mismatch("data request changed before dhit");
            end
            prev_wait = (dmem_req.ren || dmem_req.wen) && !dmem_rsp.dhit;
            prev_req  = dmem_req;
            if (dmem_req.ren && dmem_rsp.dhit) begin
                load_addr = dmem_req.addr;
                load_seen = 1'b1;
            end
            if (dmem_req.wen && dmem_rsp.dhit)
                check_store(dmem_req.addr, dmem_req.store);
            if (halt_risen) begin
                assert (halt)
                    else report_mismatch("halt dropped after rising");
            end
            if (halt) begin
                assert (!imem_req.ren)
                    else report_mismatch("instruction request high after halt");
                if (!halt_risen) begin
                    assert (n_stores == n_expected && exp_q.size() == 0)
                        else report_problem("halt rose before all expected stores");
                end
                halt_risen = 1'b1;
            end
        end
    end

    initial begin
        nrst               = 1'b0;
        errors             = 0;
        timeouts           = 0;
        n_stores           = 0;
        cycles_after_reset = 0;
        halt_risen         = 1'b0;
        prev_wait          = 1'b0;
        load_seen          = 1'b0;
        load_addr          = '0;
        // expected stores in program order from the rv32i rules
        expect_store(32'h0000_0100, 32'd17);
        expect_store(32'h0000_0104, 32'd24);
        expect_store(32'h0000_0108, 32'd20);
        expect_store(32'h0000_010C, 32'hFFFF_FFFD);
        expect_store(32'h0000_0110, 32'd16);
        expect_store(32'h0000_0114, 32'd15);
        // word at 0x40 is fill base plus address
        expect_store(32'h0000_0118, 32'hDA7A_0040);
        expect_store(32'h0000_011C, 32'hDA7A_0045);
        // bne falls through to this one
        expect_store(32'h0000_0120, 32'd16);
        n_expected = exp_q.size();

        repeat (8) @(negedge CLK);
        nrst = 1'b1;

        wait_cycles = 0;
        while (!halt && wait_cycles < halt_timeout) begin
            @(negedge CLK);
            wait_cycles++;
        end
        if (!halt) begin
            timeouts++;
            $display("timeout: halt did not rise within %0d cycles", halt_timeout);
        end
        else begin
            // halt must hold with no fetch and no stores
            for (int i = 0; i < halt_watch; i++)
                @(negedge CLK);
        end

        $display("stores %0d of %0d, errors %0d, timeouts %0d",
                 n_stores, n_expected, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_memory.sv */
// Test memory model: instruction ROM with the fixed program, data RAM with LCG-driven hit delay
`timescale 1ns/100ps
`default_nettype none
`include "datapath_params.svh"

module tb_memory (
    input  logic                    CLK,
    input  datapath_pkg::imem_req_t imem_req,
    output datapath_pkg::imem_rsp_t imem_rsp,
    input  datapath_pkg::dmem_req_t dmem_req,
    output datapath_pkg::dmem_rsp_t dmem_rsp
);
    import datapath_pkg::*;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;
    localparam logic [2:0] f3_word = 3'b010;

    word_t      rom [64];
    word_t      ram [128];
    word_t      rand_state;
    logic [1:0] delay;
    logic       waiting;

    function automatic word_t r_instr(input logic [6:0] f7, input logic [2:0] f3,
                                      input regsel_t rd, input regsel_t rs1,
                                      input regsel_t rs2);
        return {f7, rs2, rs1, f3, rd, op_rtype};
    endfunction

    function automatic word_t i_instr(input logic [6:0] op, input logic [2:0] f3,
                                      input regsel_t rd, input regsel_t rs1,
                                      input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t store_instr(input regsel_t rs2, input regsel_t rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
    endfunction

    function automatic word_t branch_instr(input logic [2:0] f3, input regsel_t rs1,
                                           input regsel_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t lcg_step(input word_t s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        imem_rsp   <= '0;
        dmem_rsp   <= '0;
        rand_state = 32'd8;
        delay      = 2'd0;
        waiting    = 1'b0;
        // data word = base plus its byte address
        for (int i = 0; i < 128; i++)
            ram[i] = 32'hDA7A_0000 + i * 4;
        // anything fetched past the end stops the machine
        for (int i = 0; i < 64; i++)
            rom[i] = `HALT_INSTR;
        // register setup and dependent alu chain
        rom[0]  = i_instr(op_imm, f3_add_sub, 5'd1, 5'd0, 12'd5);
        rom[1]  = i_instr(op_imm, f3_add_sub, 5'd2, 5'd0, 12'd12);
        rom[2]  = i_instr(op_imm, f3_add_sub, 5'd3, 5'd0, 12'hFF9);
        rom[3]  = r_instr(f7_base, f3_add_sub, 5'd4, 5'd1, 5'd2);
        rom[4]  = r_instr(f7_alt, f3_add_sub, 5'd5, 5'd4, 5'd3);
        rom[5]  = r_instr(f7_base, f3_xor, 5'd6, 5'd5, 5'd2);
        rom[6]  = r_instr(f7_base, f3_or, 5'd7, 5'd6, 5'd3);
        rom[7]  = r_instr(f7_base, f3_and, 5'd8, 5'd6, 5'd4);
        rom[8]  = i_instr(op_imm, f3_add_sub, 5'd9, 5'd8, 12'hFFF);
        rom[9]  = i_instr(op_imm, f3_add_sub, 5'd20, 5'd0, 12'h100);
        // results out to 0x100 onward
        rom[10] = store_instr(5'd4, 5'd20, 12'd0);
        rom[11] = store_instr(5'd5, 5'd20, 12'd4);
        rom[12] = store_instr(5'd6, 5'd20, 12'd8);
        rom[13] = store_instr(5'd7, 5'd20, 12'd12);
        rom[14] = store_instr(5'd8, 5'd20, 12'd16);
        rom[15] = store_instr(5'd9, 5'd20, 12'd20);
        // load-use pair
        rom[16] = i_instr(op_load, f3_word, 5'd10, 5'd0, 12'h040);
        rom[17] = r_instr(f7_base, f3_add_sub, 5'd11, 5'd10, 5'd1);
        rom[18] = store_instr(5'd10, 5'd20, 12'd24);
        rom[19] = store_instr(5'd11, 5'd20, 12'd28);
        // taken beq over the poison store, then a bne that falls through
        rom[20] = i_instr(op_imm, f3_add_sub, 5'd13, 5'd0, 12'd16);
        rom[21] = branch_instr(f3_beq, 5'd13, 5'd8, 13'd8);
        rom[22] = store_instr(5'd1, 5'd0, 12'h1F0);
        rom[23] = branch_instr(f3_bne, 5'd13, 5'd8, 13'd8);
        rom[24] = store_instr(5'd13, 5'd20, 12'd32);
        rom[25] = `HALT_INSTR;
    end

    // responses change on the falling edge only
    always @(negedge CLK) begin
        imem_rsp.ihit <= 1'b1;
        imem_rsp.load <= rom[imem_req.addr[7:2]];
        dmem_rsp.dhit <= 1'b0;
        if ((dmem_req.ren || dmem_req.wen) && !dmem_rsp.dhit) begin
            // new request picks a delay of 0 to 3 cycles
            if (!waiting) begin
                rand_state = lcg_step(rand_state);
                delay      = rand_state[17:16];
                waiting    = 1'b1;
            end
            if (delay == 2'd0) begin
                waiting       = 1'b0;
                dmem_rsp.dhit <= 1'b1;
                if (dmem_req.ren)
                    dmem_rsp.load <= ram[dmem_req.addr[8:2]];
                else
                    ram[dmem_req.addr[8:2]] = dmem_req.store;
            end
            else begin
                delay = delay - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sc_datapath.sv */
// Top of the scalar pipeline: connects fetch, scoreboard, execute and writeback to the memory ports
`timescale 1ns/100ps
`default_nettype none

module sc_datapath (
    input  logic                    CLK,
    input  logic                    nrst,
    output datapath_pkg::imem_req_t imem_req,
    input  datapath_pkg::imem_rsp_t imem_rsp,
    output datapath_pkg::dmem_req_t dmem_req,
    input  datapath_pkg::dmem_rsp_t dmem_rsp,
    output logic                    halt
);
    import datapath_pkg::*;

    fetch_t    fetch;
    issue_t    issue;
    execute_t  ex;
    wb_t       wb;
    redirect_t redirect;
    logic      freeze;
    logic      busy;

    fetch_stage i_fetch (
        .CLK       (CLK),
        .nrst      (nrst),
        .ihit      (imem_rsp.ihit),
        .imemload  (imem_rsp.load),
        .freeze    (freeze),
        .redirect  (redirect),
        .halted    (halt),
        .imem_req  (imem_req),
        .fetch_out (fetch)
    );

    scoreboard i_scoreboard (
        .CLK       (CLK),
        .nrst      (nrst),
        .fetch     (fetch),
        .wb        (wb),
        .redirect  (redirect),
        .busy      (busy),
        .freeze    (freeze),
        .issue_out (issue)
    );

    execute i_execute (
        .CLK      (CLK),
        .nrst     (nrst),
        .issue    (issue),
        .dmem_rsp (dmem_rsp),
        .dmem_req (dmem_req),
        .busy     (busy),
        .redirect (redirect),
        .ex_out   (ex)
    );

    // halt also stops instruction requests in fetch
    writeback i_writeback (
        .CLK   (CLK),
        .nrst  (nrst),
        .ex_in (ex),
        .wb    (wb),
        .halt  (halt)
    );

endmodule

`default_nettype wire

/* hdl/writeback.sv */
// Writeback stage: latches execute results, drives the register write and the sticky halt
`timescale 1ns/100ps
`default_nettype none

module writeback (
    input  logic                   CLK,
    input  logic                   nrst,
    input  datapath_pkg::execute_t ex_in,
    output datapath_pkg::wb_t      wb,
    output logic                   halt
);
    import datapath_pkg::*;

    execute_t ex_q;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ex_q <= '0;
            halt <= 1'b0;
        end
        else begin
            ex_q <= ex_in;
            if (ex_q.valid && ex_q.halt)
                halt <= 1'b1;
        end
    end

    // only valid entries write
    assign wb.reg_en  = ex_q.valid && ex_q.reg_en;
    assign wb.reg_sel = ex_q.reg_sel;
    assign wb.wdat    = ex_q.wdat;

endmodule

`default_nettype wire

/* hdl/execute.sv */
// Execute stage: ALU, scalar load/store unit with data memory request, and branch resolution
`timescale 1ns/100ps
`default_nettype none

module execute (
    input  logic                    CLK,
    input  logic                    nrst,
    input  datapath_pkg::issue_t    issue,
    input  datapath_pkg::dmem_rsp_t dmem_rsp,
    output datapath_pkg::dmem_req_t dmem_req,
    output logic                    busy,
    output datapath_pkg::redirect_t redirect,
    output datapath_pkg::execute_t  ex_out
);
    import datapath_pkg::*;

    word_t   op_b;
    word_t   alu_res;
    word_t   ls_addr;
    word_t   ls_store;
    regsel_t ls_rd;
    logic    ls_load;
    logic    ls_active;
    logic    is_mem;
    logic    taken;

    assign is_mem = issue.valid && (issue.mem_type != mem_none);

    // alu
    assign op_b = issue.use_imm ? issue.imm : issue.rdat2;

    always_comb begin
        case (issue.alu_op)
            alu_sub: alu_res = issue.rdat1 - op_b;
            alu_and: alu_res = issue.rdat1 & op_b;
            alu_or:  alu_res = issue.rdat1 | op_b;
            alu_xor: alu_res = issue.rdat1 ^ op_b;
            default: alu_res = issue.rdat1 + op_b;
        endcase
    end

    // branch unit, predicted not taken
    always_comb begin
        case (issue.branch_type)
            br_beq:  taken = (issue.rdat1 == issue.rdat2);
            br_bne:  taken = (issue.rdat1 != issue.rdat2);
            default: taken = 1'b0;
        endcase
    end

    assign redirect.miss       = issue.valid && taken;
    assign redirect.correct_pc = issue.pc + issue.imm;

    // load/store request registers
    always_ff @(posedge CLK) begin
        if (is_mem) begin
            ls_addr  <= issue.rdat1 + issue.imm;
            ls_store <= issue.rdat2;
            ls_rd    <= issue.rd;
            ls_load  <= (issue.mem_type == mem_load);
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst)
            ls_active <= 1'b0;
        else if (is_mem)
            ls_active <= 1'b1;
        else if (dmem_rsp.dhit)
            ls_active <= 1'b0;
    end

    // request held steady until dhit
    assign dmem_req.ren   = ls_active && ls_load;
    assign dmem_req.wen   = ls_active && !ls_load;
    assign dmem_req.addr  = ls_addr;
    assign dmem_req.store = ls_store;

    // a new mem op in the issue latch also blocks the next issue
    assign busy = (ls_active && !dmem_rsp.dhit) || is_mem;

    always_comb begin
        ex_out = '0;
        if (ls_active && dmem_rsp.dhit) begin
            ex_out.valid   = 1'b1;
            ex_out.reg_en  = ls_load;
            ex_out.reg_sel = ls_rd;
            ex_out.wdat    = dmem_rsp.load;
        end
        else if (issue.valid && !is_mem) begin
            ex_out.valid   = 1'b1;
            ex_out.reg_en  = issue.reg_en;
            ex_out.reg_sel = issue.rd;
            ex_out.wdat    = alu_res;
            ex_out.halt    = issue.halt;
        end
    end

endmodule

`default_nettype wire

/* hdl/scoreboard.sv */
// Scoreboard: decode, register file, pending-write tracking, freeze and the issue latch to execute
`timescale 1ns/100ps
`default_nettype none
`include "datapath_params.svh"

module scoreboard (
    input  logic                    CLK,
    input  logic                    nrst,
    input  datapath_pkg::fetch_t    fetch,
    input  datapath_pkg::wb_t       wb,
    input  datapath_pkg::redirect_t redirect,
    input  logic                    busy,
    output logic                    freeze,
    output datapath_pkg::issue_t    issue_out
);
    import datapath_pkg::*;

    word_t             rf [`NREGS];
    logic [`NREGS-1:0] pending;
    logic              halt_seen;
    issue_t            dec;
    opcode_t           opcode;
    regsel_t           rs1;
    regsel_t           rs2;
    regsel_t           rd;
    logic [2:0]        f3;
    logic              uses_rs1;
    logic              uses_rs2;
    logic              hazard;
    logic              issue_go;

    // write-through read, x0 is hardwired
    function automatic word_t read_reg(input regsel_t sel);
        word_t val;
        if (sel == '0)
            val = '0;
        else if (wb.reg_en && wb.reg_sel == sel)
            val = wb.wdat;
        else
            val = rf[sel];
        return val;
    endfunction

    // pending and not being retired this cycle
    function automatic logic still_pending(input regsel_t sel);
        return pending[sel] && !(wb.reg_en && wb.reg_sel == sel);
    endfunction

    function automatic alu_op_t alu_from_f3(input logic [2:0] fn, input logic alt);
        alu_op_t op;
        case (fn)
            f3_add_sub: op = alt ? alu_sub : alu_add;
            f3_xor:     op = alu_xor;
            f3_or:      op = alu_or;
            f3_and:     op = alu_and;
            default:    op = alu_add;
        endcase
        return op;
    endfunction

    assign opcode = opcode_t'(fetch.instr[6:0]);
    assign rd     = fetch.instr[11:7];
    assign f3     = fetch.instr[14:12];
    assign rs1    = fetch.instr[19:15];
    assign rs2    = fetch.instr[24:20];

    // decode
    always_comb begin
        dec       = '0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        dec.pc    = fetch.pc;
        dec.rdat1 = read_reg(rs1);
        dec.rdat2 = read_reg(rs2);
        dec.valid = fetch.valid;
        if (fetch.instr == `HALT_INSTR) begin
            dec.halt = 1'b1;
        end
        else begin
            case (opcode)
                op_rtype: begin
                    dec.reg_en = 1'b1;
                    dec.alu_op = alu_from_f3(f3, fetch.instr[30]);
                    uses_rs1   = 1'b1;
                    uses_rs2   = 1'b1;
                end
                op_imm: begin
                    dec.reg_en  = 1'b1;
                    dec.alu_op  = alu_from_f3(f3, 1'b0);
                    dec.imm     = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
                    dec.use_imm = 1'b1;
                    uses_rs1    = 1'b1;
                end
                op_load: begin
                    dec.reg_en   = 1'b1;
                    dec.mem_type = mem_load;
                    dec.imm      = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
                    uses_rs1     = 1'b1;
                end
                op_store: begin
                    dec.mem_type = mem_store;
                    dec.imm      = {{20{fetch.instr[31]}}, fetch.instr[31:25], fetch.instr[11:7]};
                    uses_rs1     = 1'b1;
                    uses_rs2     = 1'b1;
                end
                op_branch: begin
                    dec.branch_type = (f3 == f3_bne) ? br_bne : (f3 == f3_beq) ? br_beq : br_none;
                    dec.imm         = {{20{fetch.instr[31]}}, fetch.instr[7],
                                       fetch.instr[30:25], fetch.instr[11:8], 1'b0};
                    uses_rs1        = 1'b1;
                    uses_rs2        = 1'b1;
                end
                // unknown words become bubbles
                default: dec.valid = 1'b0;
            endcase
        end
        // writes to x0 are dropped
        dec.reg_en = dec.reg_en && (rd != '0);
        dec.rd     = dec.reg_en ? rd : '0;
    end

    // raw on sources, waw on destination
    assign hazard = fetch.valid && ((uses_rs1 && still_pending(rs1))
                                 || (uses_rs2 && still_pending(rs2))
                                 || (dec.reg_en && still_pending(dec.rd)));
    assign freeze   = hazard || busy;
    assign issue_go = dec.valid && !freeze && !redirect.miss && !halt_seen;

    always_ff @(posedge CLK) begin
        if (wb.reg_en && wb.reg_sel != '0)
            rf[wb.reg_sel] <= wb.wdat;
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pending   <= '0;
            halt_seen <= 1'b0;
            issue_out <= '0;
        end
        else begin
            if (wb.reg_en)
                pending[wb.reg_sel] <= 1'b0;
            // set wins over a same-cycle clear
            if (issue_go && dec.reg_en)
                pending[dec.rd] <= 1'b1;
            if (issue_go && dec.halt)
                halt_seen <= 1'b1;
            issue_out <= issue_go ? dec : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
// Fetch stage that holds the PC, requests instructions and fills the fetch latch
`timescale 1ns/100ps
`default_nettype none
`include "datapath_params.svh"

module fetch_stage (
    input  logic                    CLK,
    input  logic                    nrst,
    input  logic                    ihit,
    input  datapath_pkg::word_t     imemload,
    input  logic                    freeze,
    input  datapath_pkg::redirect_t redirect,
    input  logic                    halted,
    output datapath_pkg::imem_req_t imem_req,
    output datapath_pkg::fetch_t    fetch_out
);
    import datapath_pkg::*;

    word_t pc;
    logic  fetch_en;

    // request starts one cycle after reset and stops for good on halt
    assign imem_req.ren  = fetch_en && !halted;
    assign imem_req.addr = pc;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst)
            fetch_en <= 1'b0;
        else
            fetch_en <= 1'b1;
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc        <= `RESET_PC;
            fetch_out <= '0;
        end
        else if (redirect.miss) begin
            // younger fetch is squashed
            pc              <= redirect.correct_pc;
            fetch_out.valid <= 1'b0;
        end
        else if (!freeze) begin
            if (imem_req.ren && ihit) begin
                fetch_out.valid <= 1'b1;
                fetch_out.instr <= imemload;
                fetch_out.pc    <= pc;
                pc              <= pc + 32'd4;
            end
            else begin
                // old entry was taken and nothing new arrived
                fetch_out.valid <= 1'b0;
            end
        end
        // latch and pc hold while frozen
    end

endmodule

`default_nettype wire

/* hdl/datapath_pkg.sv */
// Types shared by the pipeline stages and memory ports and imported by every datapath module
`default_nettype none
`include "datapath_params.svh"

package datapath_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [4:0]         regsel_t;

    // rv32i major opcodes in use
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_rtype  = 7'b0110011,
        op_branch = 7'b1100011
    } opcode_t;

    // funct3 values
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_t;
    typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_type_t;
    typedef enum logic [1:0] {br_none, br_beq, br_bne} branch_type_t;

    // fetch latch
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
    } fetch_t;

    // issue latch toward execute
    typedef struct packed {
        logic         valid;
        logic         halt;
        regsel_t      rd;
        logic         reg_en;
        alu_op_t      alu_op;
        mem_type_t    mem_type;
        branch_type_t branch_type;
        word_t        rdat1;
        word_t        rdat2;
        word_t        imm;
        logic         use_imm;
        word_t        pc;
    } issue_t;

    typedef struct packed {
        logic    valid;
        logic    reg_en;
        regsel_t reg_sel;
        word_t   wdat;
        logic    halt;
    } execute_t;

    typedef struct packed {
        logic    reg_en;
        regsel_t reg_sel;
        word_t   wdat;
    } wb_t;

    typedef struct packed {
        logic  miss;
        word_t correct_pc;
    } redirect_t;

    // memory ports
    typedef struct packed {
        logic  ren;
        word_t addr;
    } imem_req_t;

    typedef struct packed {
        logic  ihit;
        word_t load;
    } imem_rsp_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } dmem_req_t;

    typedef struct packed {
        logic  dhit;
        word_t load;
    } dmem_rsp_t;

endpackage

`default_nettype wire

/* hdl/datapath_params.svh */
// Word width, register count, reset PC and halt encoding shared by the datapath package and RTL
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// data and address width
`define WORD_W 32

// architectural registers
`define NREGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// all ones stops the machine
`define HALT_INSTR 32'hFFFF_FFFF

`endif
